/* common/fpu_macros.svh */
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// Single precision only
`define FPU_WIDTH 32

// Result buffer entries, power of two
`define FPU_FIFO_DEPTH 4

// Canonical quiet NaN
`define FPU_QNAN 32'h7FC00000

// Magnitudes used on overflow
`define FPU_PINF_MAG 31'h7F800000
`define FPU_MAX_MAG 31'h7F7FFFFF

`endif

/* common/fpu_pkg.sv */
`include "fpu_macros.svh"

package fpu_pkg;

  typedef enum logic [3:0] {
    OP_FADD   = 4'd0,
    OP_FSUB   = 4'd1,
    OP_FMUL   = 4'd2,
    OP_FMIN   = 4'd3,
    OP_FMAX   = 4'd4,
    OP_FSGNJ  = 4'd5,
    OP_FSGNJN = 4'd6,
    OP_FSGNJX = 4'd7,
    OP_FEQ    = 4'd8,
    OP_FLT    = 4'd9,
    OP_FLE    = 4'd10
  } fpu_op_e;

  // RISC-V frm encodings
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_DYN = 3'd7
  } fpu_rm_e;

  // Same bit order as fflags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fpu_status_t;

  // rm is always RNE or RTZ here
  typedef struct packed {
    fpu_op_e               op;
    fpu_rm_e               rm;
    logic [`FPU_WIDTH-1:0] a;
    logic [`FPU_WIDTH-1:0] b;
    logic                  rd_fp;
  } fpu_req_t;

  typedef struct packed {
    logic [`FPU_WIDTH-1:0] value;
    fpu_status_t           status;
    logic                  rd_fp;
  } fpu_res_t;

endpackage

/* hdl/fpu_operand_select.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_operand_select (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [`FPU_WIDTH-1:0] fp_rdata_a_i,
  input  logic [`FPU_WIDTH-1:0] fp_rdata_b_i,
  input  logic [`FPU_WIDTH-1:0] int_rdata_a_i,
  input  logic [`FPU_WIDTH-1:0] int_rdata_b_i,
  input  logic                  use_fp_rs1_i,
  input  logic                  use_fp_rs2_i,
  input  logic                  swap_oprnds_i,
  input  fpu_pkg::fpu_op_e      op_i,
  input  fpu_pkg::fpu_rm_e      rnd_mode_dec_i,
  input  fpu_pkg::fpu_rm_e      rnd_mode_csr_i,
  input  logic                  fp_rf_wen_wb_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  output fpu_pkg::fpu_req_t     req_o,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output logic                  busy_o
);

  import fpu_pkg::*;

  logic [`FPU_WIDTH-1:0] opa;
  logic [`FPU_WIDTH-1:0] opb;
  fpu_rm_e               rm_sel;
  fpu_req_t              req_q;
  logic                  valid_q;
  logic                  accept;

  // Free slot, or the held request leaves this cycle
  assign in_ready_o = ~valid_q | req_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  always_comb begin
    opa    = use_fp_rs1_i ? fp_rdata_a_i : int_rdata_a_i;
    opb    = use_fp_rs2_i ? fp_rdata_b_i : int_rdata_b_i;
    rm_sel = (rnd_mode_dec_i == RM_DYN) ? rnd_mode_csr_i : rnd_mode_dec_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | flush_i) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (req_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.op    <= op_i;
      // Unsupported modes fall back to nearest-even
      req_q.rm    <= (rm_sel == RM_RTZ) ? RM_RTZ : RM_RNE;
      req_q.a     <= swap_oprnds_i ? opb : opa;
      req_q.b     <= swap_oprnds_i ? opa : opb;
      req_q.rd_fp <= fp_rf_wen_wb_i;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = valid_q;
  assign busy_o      = valid_q;

  // A stalled request must not change under the datapath
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_o));

endmodule

/* fpu_core/fpu_arith.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_arith (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  input  fpu_pkg::fpu_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output fpu_pkg::fpu_res_t res_o,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output logic              busy_o
);

  import fpu_pkg::*;

  function automatic logic [31:0] ftz(input logic [31:0] x);
    ftz = (x[30:23] == 8'h00) ? {x[31], 31'b0} : x;
  endfunction

  function automatic logic is_nan(input logic [31:0] x);
    is_nan = (&x[30:23]) & (|x[22:0]);
  endfunction

  function automatic logic is_inf(input logic [31:0] x);
    is_inf = (&x[30:23]) & ~(|x[22:0]);
  endfunction

  // Stage 1 signals
  logic [31:0]        in_fa, in_fb;
  logic               sb, a_big, sticky;
  logic [23:0]        ma, mb, big_m, sm_m;
  logic [7:0]         big_e, sm_e, d;
  logic [26:0]        sm_ext, sh;
  logic [47:0]        x, y;
  logic signed [9:0]  e;
  logic               sub, sgn, zsgn;
  logic               s1_v, s2_v, s1_adv, s2_adv;
  fpu_req_t           s1_req;
  logic [47:0]        s1_x, s1_y;
  logic signed [9:0]  s1_e;
  logic               s1_sub, s1_sgn, s1_zsgn;

  // Stage 2 signals
  logic [47:0]        m, norm;
  logic [5:0]         lz;
  logic               grd, stk, inc;
  logic [23:0]        rnd;
  logic signed [9:0]  e_f;
  logic [31:0]        ar_val, r_val, fa, fb;
  fpu_status_t        ar_st, r_st;
  logic               a_nan, b_nan, a_snan, b_snan, a_inf, b_inf, a_zero, b_zero;
  logic               lt_tot, both_zero, flt, feq;
  fpu_res_t           res_q;

  assign s2_adv      = ~s2_v | res_ready_i;
  assign s1_adv      = ~s1_v | s2_adv;
  assign req_ready_o = s1_adv;

  // Align for add/sub, or form the product
  always_comb begin
    in_fa  = ftz(req_i.a);
    in_fb  = ftz(req_i.b);
    sb     = in_fb[31] ^ (req_i.op == OP_FSUB);
    a_big  = in_fa[30:0] >= in_fb[30:0];
    ma     = {|in_fa[30:23], in_fa[22:0]};
    mb     = {|in_fb[30:23], in_fb[22:0]};
    big_m  = a_big ? ma : mb;
    sm_m   = a_big ? mb : ma;
    big_e  = a_big ? in_fa[30:23] : in_fb[30:23];
    sm_e   = a_big ? in_fb[30:23] : in_fa[30:23];
    d      = big_e - sm_e;
    sm_ext = {sm_m, 3'b000};
    sh     = sm_ext >> d;
    sticky = (sh << d) != sm_ext;
    if (req_i.op == OP_FMUL) begin
      x    = ma * mb;
      y    = '0;
      sub  = 1'b0;
      sgn  = in_fa[31] ^ in_fb[31];
      zsgn = sgn;
      e    = $signed({2'b00, in_fa[30:23]}) + $signed({2'b00, in_fb[30:23]}) - 10'sd127;
    end else begin
      // Hidden bit lands on bit 46, carry on bit 47
      x    = {1'b0, big_m, 23'b0};
      y    = {1'b0, sh[26:1], sh[0] | sticky, 20'b0};
      sub  = in_fa[31] ^ sb;
      sgn  = a_big ? in_fa[31] : sb;
      zsgn = sub ? 1'b0 : in_fa[31];
      e    = $signed({2'b00, big_e});
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | flush_i) begin
      s1_v <= 1'b0;
      s2_v <= 1'b0;
    end else begin
      if (s1_adv) begin
        s1_v <= req_valid_i;
      end
      if (s2_adv) begin
        s2_v <= s1_v;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_adv & req_valid_i) begin
      s1_req  <= req_i;
      s1_x    <= x;
      s1_y    <= y;
      s1_e    <= e;
      s1_sub  <= sub;
      s1_sgn  <= sgn;
      s1_zsgn <= zsgn;
    end
  end

  // Normalize and round
  always_comb begin
    m  = s1_sub ? s1_x - s1_y : s1_x + s1_y;
    lz = 6'd0;
    for (int i = 0; i < 48; i++) begin
      if (m[i]) begin
        lz = 6'(47 - i);
      end
    end
    norm  = m << lz;
    grd   = norm[23];
    stk   = |norm[22:0];
    inc   = (s1_req.rm == RM_RNE) & grd & (stk | norm[24]);
    rnd   = {1'b0, norm[46:24]} + {23'b0, inc};
    e_f   = s1_e + 10'sd1 - $signed({4'b0, lz}) + $signed({9'b0, rnd[23]});
    ar_st = '0;
    if (m == '0) begin
      ar_val = {s1_zsgn, 31'b0};
    end else if (e_f >= 10'sd255) begin
      ar_val   = (s1_req.rm == RM_RTZ) ? {s1_sgn, `FPU_MAX_MAG} : {s1_sgn, `FPU_PINF_MAG};
      ar_st.of = 1'b1;
      ar_st.nx = 1'b1;
    end else if (e_f <= 10'sd0) begin
      // Too small for a normal, flush
      ar_val   = {s1_sgn, 31'b0};
      ar_st.uf = 1'b1;
      ar_st.nx = 1'b1;
    end else begin
      ar_val   = {s1_sgn, e_f[7:0], rnd[22:0]};
      ar_st.nx = grd | stk;
    end
  end

  // Special values, min/max, sign injection, compares
  always_comb begin
    fa        = ftz(s1_req.a);
    fb        = ftz(s1_req.b);
    a_nan     = is_nan(fa);
    b_nan     = is_nan(fb);
    a_snan    = a_nan & ~fa[22];
    b_snan    = b_nan & ~fb[22];
    a_inf     = is_inf(fa);
    b_inf     = is_inf(fb);
    a_zero    = fa[30:23] == 8'h00;
    b_zero    = fb[30:23] == 8'h00;
    both_zero = a_zero & b_zero;
    // Orders -0 below +0, used as is by min/max
    lt_tot    = (fa[31] != fb[31]) ? fa[31] :
                (fa[31] ? (fa[30:0] > fb[30:0]) : (fa[30:0] < fb[30:0]));
    flt       = lt_tot & ~both_zero & ~a_nan & ~b_nan;
    feq       = ((fa == fb) | both_zero) & ~a_nan & ~b_nan;
    r_val     = `FPU_QNAN;
    r_st      = '0;
    case (s1_req.op)
      OP_FADD, OP_FSUB: begin
        if (a_nan | b_nan) begin
          r_st.nv = a_snan | b_snan;
        end else if (a_inf & b_inf & s1_sub) begin
          r_st.nv = 1'b1;
        end else if (a_inf | b_inf) begin
          r_val = {s1_sgn, `FPU_PINF_MAG};
        end else begin
          r_val = ar_val;
          r_st  = ar_st;
        end
      end
      OP_FMUL: begin
        if (a_nan | b_nan) begin
          r_st.nv = a_snan | b_snan;
        end else if ((a_inf & b_zero) | (b_inf & a_zero)) begin
          r_st.nv = 1'b1;
        end else if (a_inf | b_inf) begin
          r_val = {s1_sgn, `FPU_PINF_MAG};
        end else begin
          r_val = ar_val;
          r_st  = ar_st;
        end
      end
      OP_FMIN, OP_FMAX: begin
        r_st.nv = a_snan | b_snan;
        if (a_nan & ~b_nan) begin
          r_val = fb;
        end else if (b_nan & ~a_nan) begin
          r_val = fa;
        end else if (~a_nan) begin
          r_val = ((s1_req.op == OP_FMIN) == lt_tot) ? fa : fb;
        end
      end
      OP_FSGNJ:  r_val = {s1_req.b[31], s1_req.a[30:0]};
      OP_FSGNJN: r_val = {~s1_req.b[31], s1_req.a[30:0]};
      OP_FSGNJX: r_val = {s1_req.a[31] ^ s1_req.b[31], s1_req.a[30:0]};
      OP_FEQ: begin
        r_val   = {31'b0, feq};
        r_st.nv = a_snan | b_snan;
      end
      OP_FLT: begin
        r_val   = {31'b0, flt};
        r_st.nv = a_nan | b_nan;
      end
      OP_FLE: begin
        r_val   = {31'b0, flt | feq};
        r_st.nv = a_nan | b_nan;
      end
      default: r_st.nv = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s2_adv & s1_v) begin
      res_q.value  <= r_val;
      res_q.status <= r_st;
      // Compares always go to the integer register file
      res_q.rd_fp  <= s1_req.rd_fp & ~(s1_req.op inside {OP_FEQ, OP_FLT, OP_FLE});
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = s2_v;
  assign busy_o      = s1_v | s2_v;

endmodule

/* fpu_core/fpu_result_fifo.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_result_fifo (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              flush_i,
  input  fpu_pkg::fpu_res_t wr_i,
  input  logic              wr_valid_i,
  output logic              wr_ready_o,
  output fpu_pkg::fpu_res_t rd_o,
  output logic              rd_valid_o,
  input  logic              rd_ready_i
);

  import fpu_pkg::*;

  localparam int fifo_depth = `FPU_FIFO_DEPTH;
  localparam int ptr_w      = $clog2(fifo_depth);

  fpu_res_t         mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign full       = count == fifo_depth;
  assign rd_valid_o = count != '0;
  assign do_rd      = rd_valid_o & rd_ready_i;
  // A pop frees the slot this write takes
  assign wr_ready_o = ~full | do_rd;
  assign do_wr      = wr_valid_i & wr_ready_o;
  assign rd_o       = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (rst_i | flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{ptr_w{1'b0}}, do_wr} - {{ptr_w{1'b0}}, do_rd};
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_i;
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    count <= fifo_depth);

  // Write-back must only pop a valid head
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_ready_i |-> rd_valid_o);

endmodule

/* hdl/fpu_writeback.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_writeback (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  fpu_pkg::fpu_res_t     head_i,
  input  logic                  head_valid_i,
  output logic                  pop_o,
  input  logic                  out_ready_i,
  output logic [`FPU_WIDTH-1:0] result_o,
  output fpu_pkg::fpu_status_t  status_o,
  output logic                  out_valid_o,
  output logic                  fp_rf_wen_o,
  output logic                  int_rf_wen_o,
  output fpu_pkg::fpu_status_t  fflags_o,
  input  logic                  fflags_clr_i
);

  assign result_o     = head_i.value;
  assign status_o     = head_i.status;
  assign out_valid_o  = head_valid_i;
  assign pop_o        = head_valid_i & out_ready_i;

  // One enable per accepted result
  assign fp_rf_wen_o  = pop_o & head_i.rd_fp;
  assign int_rf_wen_o = pop_o & ~head_i.rd_fp;

  // Sticky flags; a result popped during the clear still counts
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fflags_o <= '0;
    end else begin
      fflags_o <= (fflags_clr_i ? 5'b0 : fflags_o) | (pop_o ? head_i.status : 5'b0);
    end
  end

endmodule

/* hdl/fpu_subsystem_top.sv */
`timescale 1ns/1ps
`include "fpu_macros.svh"

module fpu_subsystem_top (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [`FPU_WIDTH-1:0] fp_rdata_a_i,
  input  logic [`FPU_WIDTH-1:0] fp_rdata_b_i,
  input  logic [`FPU_WIDTH-1:0] int_rdata_a_i,
  input  logic [`FPU_WIDTH-1:0] int_rdata_b_i,
  input  logic                  use_fp_rs1_i,
  input  logic                  use_fp_rs2_i,
  input  logic                  swap_oprnds_i,
  input  fpu_pkg::fpu_op_e      op_i,
  input  fpu_pkg::fpu_rm_e      rnd_mode_dec_i,
  input  fpu_pkg::fpu_rm_e      rnd_mode_csr_i,
  input  logic                  fp_rf_wen_wb_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic                  flush_i,
  output logic [`FPU_WIDTH-1:0] result_o,
  output fpu_pkg::fpu_status_t  status_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  fp_rf_wen_o,
  output logic                  int_rf_wen_o,
  output fpu_pkg::fpu_status_t  fflags_o,
  input  logic                  fflags_clr_i,
  output logic                  busy_o
);

  import fpu_pkg::*;

  fpu_req_t req;
  fpu_res_t res;
  fpu_res_t head;
  logic     req_valid, req_ready;
  logic     res_valid, res_ready;
  logic     head_valid, pop;
  logic     sel_busy, arith_busy;

  fpu_operand_select u_operand_select (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fp_rdata_a_i   (fp_rdata_a_i),
    .fp_rdata_b_i   (fp_rdata_b_i),
    .int_rdata_a_i  (int_rdata_a_i),
    .int_rdata_b_i  (int_rdata_b_i),
    .use_fp_rs1_i   (use_fp_rs1_i),
    .use_fp_rs2_i   (use_fp_rs2_i),
    .swap_oprnds_i  (swap_oprnds_i),
    .op_i           (op_i),
    .rnd_mode_dec_i (rnd_mode_dec_i),
    .rnd_mode_csr_i (rnd_mode_csr_i),
    .fp_rf_wen_wb_i (fp_rf_wen_wb_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .flush_i        (flush_i),
    .req_o          (req),
    .req_valid_o    (req_valid),
    .req_ready_i    (req_ready),
    .busy_o         (sel_busy)
  );

  fpu_arith u_arith (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .req_i       (req),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .res_o       (res),
    .res_valid_o (res_valid),
    .res_ready_i (res_ready),
    .busy_o      (arith_busy)
  );

  fpu_result_fifo u_result_fifo (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flush_i    (flush_i),
    .wr_i       (res),
    .wr_valid_i (res_valid),
    .wr_ready_o (res_ready),
    .rd_o       (head),
    .rd_valid_o (head_valid),
    .rd_ready_i (pop)
  );

  fpu_writeback u_writeback (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .head_i       (head),
    .head_valid_i (head_valid),
    .pop_o        (pop),
    .out_ready_i  (out_ready_i),
    .result_o     (result_o),
    .status_o     (status_o),
    .out_valid_o  (out_valid_o),
    .fp_rf_wen_o  (fp_rf_wen_o),
    .int_rf_wen_o (int_rf_wen_o),
    .fflags_o     (fflags_o),
    .fflags_clr_i (fflags_clr_i)
  );

  // Anything held in the producer, the pipeline or the buffer
  assign busy_o = sel_busy | arith_busy | head_valid;

endmodule

/* test/fpu_tb_clock.sv */
`timescale 1ns/1ps

module fpu_tb_clock (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for 8 rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

/* test/fpu_tb.sv */
`timescale 1ns/1ps

module fpu_tb;

  import fpu_pkg::*;

  logic        clk, rst;
  logic [31:0] fp_rdata_a_i, fp_rdata_b_i, int_rdata_a_i, int_rdata_b_i;
  logic        use_fp_rs1_i, use_fp_rs2_i, swap_oprnds_i;
  fpu_op_e     op_i;
  fpu_rm_e     rnd_mode_dec_i, rnd_mode_csr_i;
  logic        fp_rf_wen_wb_i, in_valid_i, flush_i, out_ready_i, fflags_clr_i;
  logic        in_ready_o, out_valid_o, fp_rf_wen_o, int_rf_wen_o, busy_o;
  logic [31:0] result_o;
  fpu_status_t status_o, fflags_o;

  // Test table loaded from the data file
  logic [3:0]  t_op [64];
  logic [2:0]  t_dec [64], t_csr [64];
  logic        t_f1 [64], t_f2 [64], t_sw [64], t_wb [64];
  logic [31:0] t_fpa [64], t_fpb [64], t_inta [64], t_intb [64], t_res [64];
  logic [4:0]  t_st [64];
  int          n_tests;

  int          pending[$];
  int          expq[$];
  logic [31:0] lfsr_state = 32'h161352c8;
  int          ready_mode;
  int          cur_idx;
  logic        req_held;
  logic        prev_pop, prev_clr;
  logic [4:0]  prev_st, exp_flags;
  int          errors, tests_passed, tests_failed, dropped;
  int          cycles, limit;

  fpu_tb_clock u_clock (
    .clk_o (clk),
    .rst_o (rst)
  );

  fpu_subsystem_top UUT (
    .clk_i          (clk),
    .rst_i          (rst),
    .fp_rdata_a_i   (fp_rdata_a_i),
    .fp_rdata_b_i   (fp_rdata_b_i),
    .int_rdata_a_i  (int_rdata_a_i),
    .int_rdata_b_i  (int_rdata_b_i),
    .use_fp_rs1_i   (use_fp_rs1_i),
    .use_fp_rs2_i   (use_fp_rs2_i),
    .swap_oprnds_i  (swap_oprnds_i),
    .op_i           (op_i),
    .rnd_mode_dec_i (rnd_mode_dec_i),
    .rnd_mode_csr_i (rnd_mode_csr_i),
    .fp_rf_wen_wb_i (fp_rf_wen_wb_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .flush_i        (flush_i),
    .result_o       (result_o),
    .status_o       (status_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .fp_rf_wen_o    (fp_rf_wen_o),
    .int_rf_wen_o   (int_rf_wen_o),
    .fflags_o       (fflags_o),
    .fflags_clr_i   (fflags_clr_i),
    .busy_o         (busy_o)
  );

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    logic [8*200-1:0] line_buf;
    logic [31:0] f [13];
    fd = $fopen("test/fpu_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/fpu_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_tests < 64) begin
        line_buf = '0;
        void'($fgets(line_buf, fd));
        n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12]);
        // Comment and blank lines do not parse
        if (n == 13) begin
          t_op[n_tests]   = f[0][3:0];
          t_dec[n_tests]  = f[1][2:0];
          t_csr[n_tests]  = f[2][2:0];
          t_f1[n_tests]   = f[3][0];
          t_f2[n_tests]   = f[4][0];
          t_sw[n_tests]   = f[5][0];
          t_wb[n_tests]   = f[6][0];
          t_fpa[n_tests]  = f[7];
          t_fpb[n_tests]  = f[8];
          t_inta[n_tests] = f[9];
          t_intb[n_tests] = f[10];
          t_res[n_tests]  = f[11];
          t_st[n_tests]   = f[12][4:0];
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic drive_request(input int idx);
    op_i           = fpu_op_e'(t_op[idx]);
    rnd_mode_dec_i = fpu_rm_e'(t_dec[idx]);
    rnd_mode_csr_i = fpu_rm_e'(t_csr[idx]);
    use_fp_rs1_i   = t_f1[idx];
    use_fp_rs2_i   = t_f2[idx];
    swap_oprnds_i  = t_sw[idx];
    fp_rf_wen_wb_i = t_wb[idx];
    fp_rdata_a_i   = t_fpa[idx];
    fp_rdata_b_i   = t_fpb[idx];
    int_rdata_a_i  = t_inta[idx];
    int_rdata_b_i  = t_intb[idx];
  endtask

  // One clock cycle, entered and left just after a falling edge
  task automatic run_cycle(input logic clr, input logic flsh);
    logic b0, b1;
    logic exp_fp;
    logic ok;
    int   idx;
    if (prev_clr) begin
      exp_flags = 5'b0;
    end
    if (prev_pop) begin
      exp_flags = exp_flags | prev_st;
    end
    if (fflags_o !== exp_flags) begin
      $display("MISMATCH fflags_o: got %h expected %h", fflags_o, exp_flags);
      errors++;
    end
    if (!req_held) begin
      in_valid_i = 1'b0;
      if (pending.size() > 0) begin
        take_bit(b0);
        take_bit(b1);
        if (b0 | b1) begin
          cur_idx = pending.pop_front();
          drive_request(cur_idx);
          in_valid_i = 1'b1;
          req_held   = 1'b1;
        end
      end
    end
    if (ready_mode == 0) begin
      take_bit(b0);
      out_ready_i = b0;
    end else begin
      out_ready_i = (ready_mode == 2);
    end
    fflags_clr_i = clr;
    flush_i      = flsh;
    #1;
    prev_pop = out_valid_o & out_ready_i;
    prev_clr = clr;
    prev_st  = 5'b0;
    if (!prev_pop) begin
      if ((fp_rf_wen_o | int_rf_wen_o) !== 1'b0) begin
        $display("MISMATCH fp_rf_wen_o/int_rf_wen_o: got %h/%h expected 0/0",
                 fp_rf_wen_o, int_rf_wen_o);
        errors++;
      end
    end else if (expq.size() == 0) begin
      $display("A result came out with no request outstanding");
      errors++;
    end else begin
      idx     = expq.pop_front();
      ok      = 1'b1;
      prev_st = t_st[idx];
      exp_fp  = t_wb[idx] & (t_op[idx] < 4'd8);
      if (result_o !== t_res[idx]) begin
        $display("MISMATCH result_o: got %h expected %h", result_o, t_res[idx]);
        ok = 1'b0;
      end
      if (status_o !== t_st[idx]) begin
        $display("MISMATCH status_o: got %h expected %h", status_o, t_st[idx]);
        ok = 1'b0;
      end
      if (fp_rf_wen_o !== exp_fp) begin
        $display("MISMATCH fp_rf_wen_o: got %h expected %h", fp_rf_wen_o, exp_fp);
        ok = 1'b0;
      end
      if (int_rf_wen_o !== ~exp_fp) begin
        $display("MISMATCH int_rf_wen_o: got %h expected %h", int_rf_wen_o, ~exp_fp);
        ok = 1'b0;
      end
      if (ok) begin
        tests_passed++;
        $display("test %0d op %0h: pass", idx, t_op[idx]);
      end else begin
        tests_failed++;
        errors++;
        $display("test %0d op %0h: FAIL", idx, t_op[idx]);
      end
    end
    if (in_valid_i & in_ready_o & ~flsh) begin
      expq.push_back(cur_idx);
      req_held = 1'b0;
    end
    @(negedge clk);
  endtask

  // Watchdog
  always @(negedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, results still missing", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    fp_rdata_a_i   = '0;
    fp_rdata_b_i   = '0;
    int_rdata_a_i  = '0;
    int_rdata_b_i  = '0;
    use_fp_rs1_i   = 1'b0;
    use_fp_rs2_i   = 1'b0;
    swap_oprnds_i  = 1'b0;
    op_i           = OP_FADD;
    rnd_mode_dec_i = RM_RNE;
    rnd_mode_csr_i = RM_RNE;
    fp_rf_wen_wb_i = 1'b0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b0;
    fflags_clr_i   = 1'b0;
    req_held       = 1'b0;
    prev_pop       = 1'b0;
    prev_clr       = 1'b0;
    prev_st        = 5'b0;
    exp_flags      = 5'b0;
    load_tests();
    limit = 20 * (n_tests + 4) + 100;

    @(negedge clk);
    while (rst) begin
      @(negedge clk);
    end
    if (in_ready_o !== 1'b1 || out_valid_o !== 1'b0 || busy_o !== 1'b0 ||
        fp_rf_wen_o !== 1'b0 || int_rf_wen_o !== 1'b0 || fflags_o !== 5'b0) begin
      $display("Outputs are not at their reset values after reset");
      errors++;
    end

    // Whole table under random gaps and back-pressure
    ready_mode = 0;
    for (int i = 0; i < n_tests; i++) begin
      pending.push_back(i);
    end
    while (pending.size() > 0 || req_held || expq.size() > 0) begin
      run_cycle(1'b0, 1'b0);
    end

    // Clear the sticky flags and check them on the next cycle
    run_cycle(1'b1, 1'b0);
    run_cycle(1'b0, 1'b0);
    $display("fflags clear done");

    // Fill the pipe with the output stalled, then flush
    ready_mode = 1;
    pending.push_back(0);
    pending.push_back(4);
    pending.push_back(16);
    while (pending.size() > 0 || req_held) begin
      run_cycle(1'b0, 1'b0);
    end
    if (busy_o !== 1'b1) begin
      $display("busy_o is low while requests are in flight");
      errors++;
    end
    run_cycle(1'b0, 1'b1);
    dropped = expq.size();
    expq.delete();
    if (dropped == 0) begin
      $display("Flush found no request in flight");
      errors++;
    end
    if (busy_o !== 1'b0 || out_valid_o !== 1'b0) begin
      $display("busy_o or out_valid_o still high after flush");
      errors++;
    end
    $display("flush dropped %0d requests", dropped);

    ready_mode = 0;
    pending.push_back(2);
    while (pending.size() > 0 || req_held || expq.size() > 0) begin
      run_cycle(1'b0, 1'b0);
    end
    run_cycle(1'b0, 1'b0);

    $display("%0d tests passed, %0d failed, %0d dropped by flush, %0d errors",
             tests_passed, tests_failed, dropped, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* test/fpu_tests.txt */
# op rm_dec rm_csr use_fp1 use_fp2 swap wb fp_a fp_b int_a int_b exp_result exp_status
# status bits are nv dz of uf nx, all fields in hex
0 0 0 1 1 0 1 3F800000 40000000 00000000 00000000 40400000 00
0 0 0 1 1 0 1 3F800000 33800000 00000000 00000000 3F800000 01
0 0 0 1 1 0 1 3F800000 33C00000 00000000 00000000 3F800001 01
0 1 0 1 1 0 1 3F800000 33C00000 00000000 00000000 3F800000 01
2 0 0 1 1 0 1 7F000000 40000000 00000000 00000000 7F800000 05
2 1 0 1 1 0 1 7F000000 40000000 00000000 00000000 7F7FFFFF 05
2 0 0 1 1 0 1 00800000 3F000000 00000000 00000000 00000000 03
2 0 0 1 1 0 1 3FC00000 40000000 00000000 00000000 40400000 00
1 0 0 1 1 0 1 40400000 3F800000 00000000 00000000 40000000 00
1 0 0 1 1 1 1 3F800000 40400000 00000000 00000000 40000000 00
0 7 1 1 1 0 1 3F800000 33C00000 00000000 00000000 3F800000 01
0 7 0 1 1 0 1 3F800000 33C00000 00000000 00000000 3F800001 01
0 0 0 0 1 0 1 12345678 3F800000 40000000 00000000 40400000 00
0 0 0 1 0 0 1 3F800000 DEADBEEF 00000000 3F800000 40000000 00
9 0 0 1 1 1 1 3F800000 40000000 00000000 00000000 00000000 00
9 0 0 1 1 0 0 3F800000 40000000 00000000 00000000 00000001 00
1 0 0 1 1 0 1 7F800000 7F800000 00000000 00000000 7FC00000 10
0 0 0 1 1 0 1 7F800000 3F800000 00000000 00000000 7F800000 00
2 0 0 1 1 0 1 7F800000 00000000 00000000 00000000 7FC00000 10
3 0 0 1 1 0 1 7FC00000 3F800000 00000000 00000000 3F800000 00
4 0 0 1 1 0 1 7F800001 40000000 00000000 00000000 40000000 10
3 0 0 1 1 0 1 00000000 80000000 00000000 00000000 80000000 00
4 0 0 1 1 0 1 00000000 80000000 00000000 00000000 00000000 00
3 0 0 1 1 0 1 7FC00000 7FC00000 00000000 00000000 7FC00000 00
5 0 0 1 1 0 1 3F800000 C0000000 00000000 00000000 BF800000 00
6 0 0 1 1 0 1 3F800000 3F800000 00000000 00000000 BF800000 00
7 0 0 1 1 0 1 BF800000 C0000000 00000000 00000000 3F800000 00
8 0 0 1 1 0 1 7FC00000 7FC00000 00000000 00000000 00000000 00
8 0 0 1 1 0 1 7F800001 3F800000 00000000 00000000 00000000 10
9 0 0 1 1 0 1 7FC00000 3F800000 00000000 00000000 00000000 10
a 0 0 1 1 0 1 40000000 40000000 00000000 00000000 00000001 00
8 0 0 1 1 0 1 00000000 80000000 00000000 00000000 00000001 00
0 0 0 1 1 0 0 3F800000 3F800000 00000000 00000000 40000000 00
0 0 0 1 1 0 1 00400000 3F800000 00000000 00000000 3F800000 00
1 0 0 1 1 0 1 3F800001 3F800000 00000000 00000000 34000000 00

/* build.f */
+incdir+common
common/fpu_pkg.sv
hdl/fpu_operand_select.sv
fpu_core/fpu_arith.sv
fpu_core/fpu_result_fifo.sv
hdl/fpu_writeback.sv
hdl/fpu_subsystem_top.sv
test/fpu_tb_clock.sv
test/fpu_tb.sv
